//--- source/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// --------------------
// Datapath widths
// --------------------
`define LSU_XLEN        32
`define LSU_IMM_W       12

// --------------------
// Local memory
// --------------------
`define LSU_ADDR_W      12    // Byte address
`define LSU_DMEM_WORDS  1024  // Must cover LSU_ADDR_W

`endif

//--- source/lsu_op_pkg.sv
`include "lsu_macros.svh"

package lsu_op_pkg;

  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } size_t;

  typedef enum logic {
    SIGN_U = 1'b0,
    SIGN_S = 1'b1
  } sign_t;

  typedef logic [4:0] reg_idx_t;

  // Decoded load/store control
  typedef struct packed {
    size_t size;
    sign_t sign;
    logic  is_load;
    logic  is_store;
  } pipe_ctrl_t;

  // Operation as it leaves the issue stage
  typedef struct packed {
    pipe_ctrl_t              ctrl;
    logic [`LSU_XLEN-1:0]    base;
    logic [`LSU_IMM_W-1:0]   imm;
    logic [`LSU_XLEN-1:0]    st_data;
    reg_idx_t                rd;
  } issue_t;

endpackage

//--- source/lsu_mem_pkg.sv
`include "lsu_macros.svh"

package lsu_mem_pkg;

  localparam int BYTES    = `LSU_XLEN / 8;
  localparam int OFFSET_W = $clog2(BYTES);

  typedef logic [`LSU_ADDR_W-OFFSET_W-1:0] word_addr_t;
  typedef logic [OFFSET_W-1:0]             offset_t;
  typedef logic [BYTES-1:0]                byte_en_t;

  typedef enum logic [1:0] {
    EXC_NONE        = 2'd0,
    EXC_LD_MISALIGN = 2'd1,
    EXC_ST_MISALIGN = 2'd2
  } except_t;

  // EX1 result, one word access
  typedef struct packed {
    word_addr_t              word_addr;
    offset_t                 offset;
    byte_en_t                byte_en;
    logic [`LSU_XLEN-1:0]    wdata;     // Already in its byte lanes
    lsu_op_pkg::pipe_ctrl_t  ctrl;
    lsu_op_pkg::reg_idx_t    rd;
    except_t                 except;
  } mem_req_t;

  typedef struct packed {
    logic                    rd_valid;
    lsu_op_pkg::reg_idx_t    rd;
    logic [`LSU_XLEN-1:0]    data;
    logic                    is_store;
    except_t                 except;
  } wb_t;

endpackage

//--- source/lsu_stage.sv
module lsu_stage #(
  parameter type T = logic
) (
  input  logic i_clk,
  input  logic i_reset_n,

  input  logic i_valid,
  output logic o_ready,
  input  T     i_data,

  output logic o_valid,
  input  logic i_ready,
  output T     o_data
);

  logic r_full;
  T     r_data;

  // Refill in the same cycle the held item leaves
  assign o_ready = !r_full || i_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_full <= 1'b0;
    end else if (o_ready) begin
      r_full <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_valid && o_ready) begin
      r_data <= i_data;
    end
  end

  assign o_valid = r_full;
  assign o_data  = r_data;

endmodule

//--- source/lsu_agen.sv
`include "lsu_macros.svh"

module lsu_agen (
  input  lsu_op_pkg::issue_t    i_issue,
  output lsu_mem_pkg::mem_req_t o_req
);

  import lsu_op_pkg::*;
  import lsu_mem_pkg::*;

  logic [`LSU_XLEN-1:0] w_imm_sext;
  logic [`LSU_XLEN-1:0] w_vaddr;
  offset_t              w_offset;
  logic                 w_misalign;
  byte_en_t             w_size_mask;

  // --------------------
  // Address
  // --------------------
  assign w_imm_sext = {{(`LSU_XLEN-`LSU_IMM_W){i_issue.imm[`LSU_IMM_W-1]}}, i_issue.imm};
  assign w_vaddr    = i_issue.base + w_imm_sext;
  assign w_offset   = w_vaddr[OFFSET_W-1:0];

  always_comb begin
    case (i_issue.ctrl.size)
      SIZE_B: begin
        w_misalign  = 1'b0;
        w_size_mask = byte_en_t'(1);
      end
      SIZE_H: begin
        w_misalign  = w_offset[0];
        w_size_mask = byte_en_t'(3);
      end
      SIZE_W: begin
        w_misalign  = (w_offset != '0);
        w_size_mask = '1;
      end
      default: begin
        w_misalign  = 1'b1;  // Undefined size never reaches RAM
        w_size_mask = '0;
      end
    endcase
  end

  // --------------------
  // Request
  // --------------------
  always_comb begin
    o_req.word_addr = w_vaddr[`LSU_ADDR_W-1:OFFSET_W];
    o_req.offset    = w_offset;
    o_req.byte_en   = i_issue.ctrl.is_store ? (w_size_mask << w_offset) : '0;
    o_req.wdata     = i_issue.st_data << {w_offset, 3'b000};
    o_req.ctrl      = i_issue.ctrl;
    o_req.rd        = i_issue.rd;

    if (!w_misalign) begin
      o_req.except = EXC_NONE;
    end else if (i_issue.ctrl.is_load) begin
      o_req.except = EXC_LD_MISALIGN;
    end else begin
      o_req.except = EXC_ST_MISALIGN;
    end
  end

endmodule

//--- source/lsu_dmem.sv
`include "lsu_macros.svh"

module lsu_dmem (
  input  logic                     i_clk,
  input  logic                     i_we,
  input  lsu_mem_pkg::word_addr_t  i_word_addr,
  input  lsu_mem_pkg::byte_en_t    i_byte_en,
  input  logic [`LSU_XLEN-1:0]     i_wdata,
  output logic [`LSU_XLEN-1:0]     o_rdata
);

  import lsu_mem_pkg::*;

  logic [`LSU_XLEN-1:0] r_mem [`LSU_DMEM_WORDS];

  // Per-lane write
  always_ff @(posedge i_clk) begin
    if (i_we) begin
      for (int b = 0; b < BYTES; b++) begin
        if (i_byte_en[b]) begin
          r_mem[i_word_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  assign o_rdata = r_mem[i_word_addr];  // Async read in EX2

endmodule

//--- source/lsu_load_align.sv
`include "lsu_macros.svh"

module lsu_load_align (
  input  lsu_mem_pkg::mem_req_t i_req,
  input  logic [`LSU_XLEN-1:0]  i_rdata,
  output lsu_mem_pkg::wb_t      o_wb
);

  import lsu_op_pkg::*;
  import lsu_mem_pkg::*;

  logic [`LSU_XLEN-1:0] w_shift;
  logic [`LSU_XLEN-1:0] w_ext;
  logic                 w_signed;
  logic                 w_ld_ok;

  assign w_shift  = i_rdata >> {i_req.offset, 3'b000};
  assign w_signed = (i_req.ctrl.sign == SIGN_S);
  assign w_ld_ok  = i_req.ctrl.is_load && (i_req.except == EXC_NONE);

  // Lane select and extend
  always_comb begin
    case (i_req.ctrl.size)
      SIZE_B:  w_ext = {{(`LSU_XLEN-8){w_signed & w_shift[7]}}, w_shift[7:0]};
      SIZE_H:  w_ext = {{(`LSU_XLEN-16){w_signed & w_shift[15]}}, w_shift[15:0]};
      SIZE_W:  w_ext = w_shift;
      default: w_ext = '0;
    endcase
  end

  always_comb begin
    o_wb.rd_valid = w_ld_ok && (i_req.rd != '0);  // x0 never written
    o_wb.rd       = i_req.rd;
    o_wb.data     = w_ld_ok ? w_ext : '0;
    o_wb.is_store = i_req.ctrl.is_store;
    o_wb.except   = i_req.except;
  end

endmodule

//--- source/lsu_pipe_top.sv
module lsu_pipe_top (
  input  logic                i_clk,
  input  logic                i_reset_n,

  input  logic                i_issue_valid,
  output logic                o_issue_ready,
  input  lsu_op_pkg::issue_t  i_issue,

  output logic                o_wb_valid,
  input  logic                i_wb_ready,
  output lsu_mem_pkg::wb_t    o_wb
);

  import lsu_op_pkg::*;
  import lsu_mem_pkg::*;

  issue_t               w_ex1_issue;
  logic                 w_ex1_valid;
  logic                 w_ex1_ready;
  mem_req_t             w_ex1_req;

  mem_req_t             w_ex2_req;
  logic                 w_ex2_valid;
  logic                 w_ex2_ready;
  logic [$bits(w_ex2_req.wdata)-1:0] w_ex2_rdata;
  wb_t                  w_ex2_wb;
  logic                 w_dmem_we;

  // --------------------
  // EX1 address
  // --------------------
  lsu_stage #(.T(issue_t)) u_ex1 (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (i_issue_valid),
    .o_ready   (o_issue_ready),
    .i_data    (i_issue),
    .o_valid   (w_ex1_valid),
    .i_ready   (w_ex1_ready),
    .o_data    (w_ex1_issue)
  );

  lsu_agen u_agen (
    .i_issue (w_ex1_issue),
    .o_req   (w_ex1_req)
  );

  // --------------------
  // EX2 memory
  // --------------------
  lsu_stage #(.T(mem_req_t)) u_ex2 (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (w_ex1_valid),
    .o_ready   (w_ex1_ready),
    .i_data    (w_ex1_req),
    .o_valid   (w_ex2_valid),
    .i_ready   (w_ex2_ready),
    .o_data    (w_ex2_req)
  );

  // Store commits once, on the edge it moves to EX3
  assign w_dmem_we = w_ex2_valid && w_ex2_ready && w_ex2_req.ctrl.is_store &&
                     (w_ex2_req.except == EXC_NONE);

  lsu_dmem u_dmem (
    .i_clk       (i_clk),
    .i_we        (w_dmem_we),
    .i_word_addr (w_ex2_req.word_addr),
    .i_byte_en   (w_ex2_req.byte_en),
    .i_wdata     (w_ex2_req.wdata),
    .o_rdata     (w_ex2_rdata)
  );

  lsu_load_align u_load_align (
    .i_req   (w_ex2_req),
    .i_rdata (w_ex2_rdata),
    .o_wb    (w_ex2_wb)
  );

  // EX3 writeback
  lsu_stage #(.T(wb_t)) u_ex3 (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_valid   (w_ex2_valid),
    .o_ready   (w_ex2_ready),
    .i_data    (w_ex2_wb),
    .o_valid   (o_wb_valid),
    .i_ready   (i_wb_ready),
    .o_data    (o_wb)
  );

endmodule

//--- tb/tb_clock_gen.sv
module tb_clock_gen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 8
) (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

  // Release away from the rising edge
  initial begin
    o_reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_reset_n = 1'b1;
  end

endmodule

//--- tb/tb_lsu_checker.sv
`include "lsu_macros.svh"

module tb_lsu_checker #(
  parameter int MAX_CASES = 32,
  parameter int TIMEOUT   = 200
) (
  input  logic             i_clk,
  input  logic             i_reset_n,
  input  logic             i_issue_valid,
  input  logic             i_issue_ready,
  input  logic             i_wb_valid,
  input  logic             i_wb_ready,
  input  lsu_mem_pkg::wb_t i_wb,
  output logic             o_done,
  output int               o_errors
);

  localparam int COLS  = 11;
  localparam int DEPTH = 3;   // Stages between issue and writeback

  logic [31:0]      cases [COLS*MAX_CASES];
  int               num_cases;
  int               accept_q [$];  // Edge number of each accepted issue
  int               cycle;
  int               last_low;      // Last edge with i_wb_ready low
  int               idle;
  int               next_case;
  int               passed;
  int               errors;
  bit               done;
  bit               stalled;       // Writeback offered but not taken
  lsu_mem_pkg::wb_t held_wb;

  function automatic bit field_ok(input string name, input logic [31:0] got,
                                  input logic [31:0] exp, input int idx);
    if (got === exp) begin
      return 1'b1;
    end
    $display("Mismatch at time %0t: case %0d %s is %h, expected %h",
             $time, idx, name, got, exp);
    return 1'b0;
  endfunction

  initial begin
    for (int i = 0; i < COLS*MAX_CASES; i++) begin
      cases[i] = '1;
    end
    $readmemh("tb/lsu_cases.txt", cases);
    num_cases = 0;
    while (num_cases < MAX_CASES && cases[num_cases*COLS] != '1) begin
      num_cases++;
    end
  end

  always @(posedge i_clk or negedge i_reset_n) begin
    int acc;
    int b;
    bit ok;
    if (!i_reset_n) begin
      cycle     = 0;
      last_low  = 0;
      idle      = 0;
      next_case = 0;
      passed    = 0;
      errors    = 0;
      done      = 1'b0;
      stalled   = 1'b0;
      o_done   <= 1'b0;
      o_errors <= 0;
    end else begin
      cycle++;
      if (!i_wb_ready) begin
        last_low = cycle;
      end

      // Issue side blocks only with every stage full and EX3 blocked
      if (i_issue_ready !== (accept_q.size() < DEPTH || i_wb_ready)) begin
        $display("Mismatch at time %0t: issue ready is %b with %0d in flight",
                 $time, i_issue_ready, accept_q.size());
        errors++;
      end

      if (stalled && (!i_wb_valid || i_wb !== held_wb)) begin
        $display("Mismatch at time %0t: writeback changed while stalled", $time);
        errors++;
      end
      stalled = i_wb_valid && !i_wb_ready;
      held_wb = i_wb;

      if (i_issue_valid && i_issue_ready) begin
        accept_q.push_back(cycle);
      end

      if (i_wb_valid && i_wb_ready) begin
        idle = 0;
        if (next_case >= num_cases || accept_q.size() == 0) begin
          $display("Extra writeback at time %0t after the last case", $time);
          errors++;
        end else begin
          acc = accept_q.pop_front();
          b   = next_case * COLS;
          ok  = field_ok("rd_valid", 32'(i_wb.rd_valid), cases[b+7], next_case);
          ok  = field_ok("rd", 32'(i_wb.rd), cases[b+6], next_case) && ok;
          ok  = field_ok("data", i_wb.data, cases[b+8], next_case) && ok;
          ok  = field_ok("is_store", 32'(i_wb.is_store), cases[b+9], next_case) && ok;
          ok  = field_ok("except", 32'(i_wb.except), cases[b+10], next_case) && ok;
          if (last_low <= acc) begin
            // No stall since acceptance
            ok = field_ok("latency", 32'(cycle - acc), 32'd3, next_case) && ok;
          end
          $display("Case %0d %s", next_case, ok ? "pass" : "fail");
          if (ok) begin
            passed++;
          end else begin
            errors++;
          end
          next_case++;
          done = (next_case == num_cases);
        end
      end else if (!done && next_case < num_cases) begin
        idle++;
        if (idle > TIMEOUT) begin
          $display("Timeout: no writeback arrived for case %0d", next_case);
          errors++;
          done = 1'b1;
        end
      end

      if (done && !o_done) begin
        $display("Checked %0d of %0d cases: %0d passed, %0d errors",
                 next_case, num_cases, passed, errors);
      end
      o_done   <= done;
      o_errors <= errors;
    end
  end

endmodule

//--- tb/tb_lsu_pipe.sv
`include "lsu_macros.svh"

module tb_lsu_pipe;

  import lsu_op_pkg::*;
  import lsu_mem_pkg::*;

  localparam int COLS       = 11;
  localparam int MAX_CASES  = 32;
  localparam int HOLD_CASES = 8;    // Latency cases, i_wb_ready held high
  localparam int TIMEOUT    = 100;

  logic        clk;
  logic        reset_n;
  logic        issue_valid;
  logic        issue_ready;
  issue_t      issue;
  logic        wb_valid;
  logic        wb_ready;
  wb_t         wb;
  logic        checks_done;
  int          error_count;
  logic [31:0] cases [COLS*MAX_CASES];
  logic        hold_ready = 1'b1;
  logic        run_error;
  int          num_cases;

  tb_clock_gen u_clock_gen (
    .o_clk     (clk),
    .o_reset_n (reset_n)
  );

  lsu_pipe_top u_lsu_pipe_top (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_issue_valid (issue_valid),
    .o_issue_ready (issue_ready),
    .i_issue       (issue),
    .o_wb_valid    (wb_valid),
    .i_wb_ready    (wb_ready),
    .o_wb          (wb)
  );

  tb_lsu_checker #(.MAX_CASES(MAX_CASES)) u_checker (
    .i_clk         (clk),
    .i_reset_n     (reset_n),
    .i_issue_valid (issue_valid),
    .i_issue_ready (issue_ready),
    .i_wb_valid    (wb_valid),
    .i_wb_ready    (wb_ready),
    .i_wb          (wb),
    .o_done        (checks_done),
    .o_errors      (error_count)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic issue_t make_issue(input int idx);
    issue_t op;
    int     b;
    b                = idx * COLS;
    op.ctrl.is_store = cases[b][0];
    op.ctrl.is_load  = !cases[b][0];
    op.ctrl.size     = size_t'(cases[b+1][1:0]);
    op.ctrl.sign     = sign_t'(cases[b+2][0]);
    op.base          = cases[b+3];
    op.imm           = cases[b+4][`LSU_IMM_W-1:0];
    op.st_data       = cases[b+5];
    op.rd            = cases[b+6][4:0];
    return op;
  endfunction

  // --------------------
  // Writeback back-pressure
  // --------------------
  initial begin
    logic [31:0] seed;
    seed     = 32'hcb8058ec;
    wb_ready = 1'b0;
    forever begin
      @(negedge clk);
      seed     = lcg_next(seed);
      wb_ready = hold_ready || seed[16];
    end
  end

  // --------------------
  // Issue sequence
  // --------------------
  initial begin
    int waited;
    bit accepted;
    issue_valid = 1'b0;
    issue       = '0;
    run_error   = 1'b0;
    for (int i = 0; i < COLS*MAX_CASES; i++) begin
      cases[i] = '1;
    end
    $readmemh("tb/lsu_cases.txt", cases);
    num_cases = 0;
    while (num_cases < MAX_CASES && cases[num_cases*COLS] != '1) begin
      num_cases++;
    end
    if (num_cases == 0) begin
      $display("No cases could be read from tb/lsu_cases.txt");
      run_error = 1'b1;
    end

    waited = 0;
    while (!reset_n && waited < TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!reset_n) begin
      $display("Reset was never released");
      run_error = 1'b1;
    end

    for (int i = 0; i < num_cases && !run_error; i++) begin
      @(negedge clk);
      issue_valid = 1'b1;
      issue       = make_issue(i);
      waited      = 0;
      accepted    = 1'b0;
      while (!accepted && waited < TIMEOUT) begin
        @(posedge clk);
        accepted = issue_ready;
        waited++;
      end
      if (!accepted) begin
        $display("Timeout: case %0d was never accepted by the pipe", i);
        run_error = 1'b1;
      end
      if (i == HOLD_CASES + 2) begin
        hold_ready = 1'b0;  // Last latency case has drained
      end
    end
    @(negedge clk);
    issue_valid = 1'b0;

    waited = 0;
    while (!checks_done && waited < 10 * TIMEOUT) begin
      @(posedge clk);
      waited++;
    end
    if (!checks_done) begin
      $display("Timeout: the checker never saw every writeback");
      run_error = 1'b1;
    end
    repeat (8) @(posedge clk);  // Room for a stray extra writeback

    if (run_error || error_count != 0) begin
      $display("Test failed");
    end else begin
      $display("Test completed successfully");
    end
    $finish;
  end

endmodule

//--- tb/lsu_cases.txt
// op(0 load,1 store) size(0 b,1 h,2 w) sign(1 signed) base imm st_data rd
// expected: rd_valid data is_store except(0 none,1 load misaligned,2 store misaligned)
1 2 0 00000100 000 8899aabb 00  0 00000000 1 0
0 0 1 00000100 000 00000000 05  1 ffffffbb 0 0
0 0 0 00000100 001 00000000 06  1 000000aa 0 0
0 0 1 00000100 002 00000000 07  1 ffffff99 0 0
0 0 0 00000100 003 00000000 08  1 00000088 0 0
0 1 1 00000100 000 00000000 09  1 ffffaabb 0 0
0 1 0 00000100 002 00000000 0a  1 00008899 0 0
0 2 0 00000104 ffc 00000000 0b  1 8899aabb 0 0
1 0 0 00000100 001 00000011 00  0 00000000 1 0
1 1 0 00000100 002 00002233 00  0 00000000 1 0
0 2 0 00000100 000 00000000 0c  1 223311bb 0 0
0 1 1 00000100 001 00000000 0d  0 00000000 0 1
1 2 0 00000100 002 deadbeef 1f  0 00000000 1 2
0 2 0 00000100 000 00000000 00  0 223311bb 0 0
0 2 0 000000f0 010 00000000 0e  1 223311bb 0 0
0 0 1 00000100 003 00000000 0f  1 00000022 0 0
0 2 1 00000100 003 00000000 10  0 00000000 0 1
1 1 0 00000100 000 0000cafe 11  0 00000000 1 0
0 1 1 00000100 000 00000000 12  1 ffffcafe 0 0
0 2 0 00000100 000 00000000 13  1 2233cafe 0 0

//--- vlog.f
+incdir+source
source/lsu_op_pkg.sv
source/lsu_mem_pkg.sv
source/lsu_stage.sv
source/lsu_agen.sv
source/lsu_dmem.sv
source/lsu_load_align.sv
source/lsu_pipe_top.sv
tb/tb_clock_gen.sv
tb/tb_lsu_checker.sv
tb/tb_lsu_pipe.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the LSU pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module tb_lsu_pipe -Mdir obj_dir -o sim_lsu \
  > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_lsu > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
